// ==== files.f ====
design/mipsPkg.sv
design/controlUnit.sv
design/registerFile.sv
design/hazardUnit.sv
design/executeStage.sv
design/dataMemory.sv
design/mipsCore.sv
verification/clockGen.sv
verification/tbMips.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tbMips
RTL_TOP  = mipsCore
FILELIST = files.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing -j 0 --Mdir $(OBJDIR)
LINTFLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== verification/tbMips.sv ====
/*
 * tbMips
 * Testbench for the pipelined MIPS core. Builds a random program
 * from a Galois LFSR, runs it on an in-order ISA model and
 * compares every writeback of the DUT with the model's record
 */
`timescale 1ns/1ps

module tbMips
	import mipsPkg::*;
();

	localparam int clkPeriod   = 10;
	localparam int resetCycles = 8;
	localparam int progLen     = 200;
	localparam int drainCycles = 8;  // Idle cycles checked after the last result
	localparam int timeoutNs   = (progLen * 2 + 50 + resetCycles) * clkPeriod;
	localparam logic [15:0] lfsrSeed = 16'd45535;
	localparam logic [15:0] lfsrTaps = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

	localparam functE       aluFns [6] = '{fnAdd, fnSub, fnAnd, fnOr, fnNor, fnSlt};
	localparam logic [5:0]  badFns [4] = '{6'h21, 6'h00, 6'h08, 6'h2B};  // addu, sll, jr, sltu
	localparam logic [5:0]  badOps [4] = '{6'h04, 6'h02, 6'h0A, 6'h0F};  // beq, j, slti, lui

	logic        clk;
	logic        rstN;
	dataT        instr_i;
	dataT        pcO_o;
	wbT          wb_o;
	logic [15:0] lfsr;
	dataT        prog [progLen];
	dataT        modelRegs [32];
	dataT        modelMem [dMemDepth];
	wbT          expQ [$];  // Expected writebacks in program order

	clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(resetCycles)) uClk (
		.clk_o (clk),
		.rstN_o(rstN)
	);

	mipsCore UUT (
		.clk_i  (clk),
		.rstN_i (rstN),
		.instr_i(instr_i),
		.pcO_o  (pcO_o),
		.wb_o   (wb_o)
	);

	////////////////////////////// Random source
	// One LFSR step per bit taken, bits shifted in from the right
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? lfsrTaps : 16'h0000);
		end
		return v;
	endfunction

	function automatic regAddrT pickReg();
		logic [15:0] v;
		v = takeBits(3);
		return {2'b00, v[2:0]};  // Only $0..$7, lots of hazards
	endfunction

	////////////////////////////// ISA model
	function automatic dataT aluModel(input logic [2:0] op, input dataT a, input dataT b);
		case (op)
			3'd0:    return a + b;
			3'd1:    return a - b;
			3'd2:    return a & b;
			3'd3:    return a | b;
			3'd4:    return ~(a | b);
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // slt is signed
		endcase
	endfunction

	task automatic modelWrite(input regAddrT dest, input dataT val);
		wbT rec;
		if (dest != '0) begin  // $zero never shows a writeback
			modelRegs[dest] = val;
			rec.valid = 1'b1;
			rec.idx   = dest;
			rec.data  = val;
			expQ.push_back(rec);
		end
	endtask

	// Builds each word and executes it on the model at once
	task automatic genProgram();
		logic [15:0] kind;
		logic [15:0] imm;
		regAddrT     rs;
		regAddrT     rt;
		regAddrT     rd;
		dataT        a;
		dataT        b;
		dataT        sImm;
		dataT        zImm;
		dataT        addr;
		for (int i = 0; i < 32; i++) modelRegs[i] = '0;
		for (int i = 0; i < dMemDepth; i++) modelMem[i] = '0;
		for (int i = 0; i < progLen; i++) begin
			kind = takeBits(4);
			rs   = pickReg();
			rt   = pickReg();
			rd   = pickReg();
			imm  = takeBits(16);
			if ((kind[3:0] >= 4'd9) && (kind[3:0] <= 4'd12) && (takeBits(1) == 16'd1)) begin
				rs  = '0;  // Absolute address in 8 words, upper bits wrap
				imm = {imm[15:8], 3'b000, imm[2:0], 2'b00};
			end
			a    = modelRegs[rs];
			b    = modelRegs[rt];
			sImm = {{16{imm[15]}}, imm};
			zImm = {16'h0000, imm};
			addr = a + sImm;
			case (kind[3:0])
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
					prog[i] = {opR, rs, rt, rd, 5'd0, aluFns[kind[2:0]]};
					modelWrite(rd, aluModel(kind[2:0], a, b));
				end
				4'd6: begin
					prog[i] = {opAddi, rs, rt, imm};
					modelWrite(rt, a + sImm);
				end
				4'd7: begin
					prog[i] = {opAndi, rs, rt, imm};
					modelWrite(rt, a & zImm);  // Zero extended
				end
				4'd8: begin
					prog[i] = {opOri, rs, rt, imm};
					modelWrite(rt, a | zImm);
				end
				4'd9, 4'd10: begin
					prog[i] = {opLw, rs, rt, imm};
					modelWrite(rt, modelMem[addr[7:2]]);
				end
				4'd11, 4'd12: begin
					prog[i] = {opSw, rs, rt, imm};
					modelMem[addr[7:2]] = b;
				end
				4'd13: prog[i] = {opR, rs, rt, rd, 5'd0, badFns[imm[1:0]]};  // No-op funct
				4'd14: prog[i] = '0;
				default: prog[i] = {badOps[imm[1:0]], rs, rt, imm};  // No-op opcode
			endcase
		end
	endtask

	function automatic dataT fetchWord(input dataT pc);
		int idx;
		idx = int'(pc >> 2);
		if ((pc >> 2) < dataT'(progLen))
			return prog[idx];
		else
			return '0;  // Past the end, zero word
	endfunction

	////////////////////////////// Checks
	task automatic stopOnError();
		$display("Verification failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkWb(input string name, input wbT expRec, input wbT actRec);
		if (expRec !== actRec) begin
			$display("FAIL %s expected valid=%0b idx=%0d data=%h actual valid=%0b idx=%0d data=%h",
			         name, expRec.valid, expRec.idx, expRec.data,
			         actRec.valid, actRec.idx, actRec.data);
			stopOnError();
		end
	endtask

	task automatic checkPc(input string name, input dataT expPc, input dataT actPc);
		if (expPc !== actPc) begin
			$display("FAIL %s expected %h actual %h", name, expPc, actPc);
			stopOnError();
		end
	endtask

	////////////////////////////// Stimulus and monitor
	// Outputs sampled and inputs driven on the falling edge
	initial begin
		wbT expRec;
		int seen;
		int drain;
		instr_i  = '0;
		seen     = 0;
		drain    = 0;
		lfsr     = lfsrSeed;
		genProgram();
		@(posedge rstN);
		@(negedge clk);
		checkPc("pc after reset", '0, pcO_o);
		while ((expQ.size() > 0) || (drain < drainCycles)) begin
			if (wb_o.valid) begin
				if (expQ.size() == 0) begin
					$display("Writeback to register %0d with no result pending", wb_o.idx);
					stopOnError();
				end else begin
					expRec = expQ.pop_front();
					checkWb($sformatf("writeback %0d", seen), expRec, wb_o);
					seen++;
				end
			end
			if (expQ.size() == 0)
				drain++;
			instr_i = fetchWord(pcO_o);
			@(negedge clk);
		end
		$display("Verification passed");
		$finish;
	end

	// Watchdog, two cycles per instruction covers every stall
	initial begin
		#(timeoutNs);
		$display("Timeout after %0d ns with %0d writebacks still pending", timeoutNs, expQ.size());
		stopOnError();
	end

endmodule

// ==== verification/clockGen.sv ====
/*
 * clockGen
 * Testbench clock and active-low reset. Reset is held for a
 * number of rising edges, then released inside the high phase
 */
`timescale 1ns/1ps

module clockGen #(
	parameter int halfPeriod  = 5,  // 10 ns clock
	parameter int resetCycles = 8
) (
	output logic clk_o,
	output logic rstN_o
);

	initial begin
		clk_o  = 1'b0;
		rstN_o = 1'b0;
		repeat (resetCycles) @(posedge clk_o);
		#(halfPeriod / 2);  // Away from both clock edges
		rstN_o = 1'b1;
	end

	always #(halfPeriod) clk_o = ~clk_o;

endmodule

// ==== design/mipsCore.sv ====
/*
 * mipsCore
 * Five-stage pipelined MIPS integer core. Holds the PC and the four
 * pipeline registers, inserts a bubble on a load-use hazard and
 * reports every register write on the writeback port
 */
`timescale 1ns/1ps

module mipsCore
	import mipsPkg::*;
(
	input  logic clk_i,
	input  logic rstN_i,
	input  dataT instr_i,   // Fetched word at pcO_o, same cycle
	output dataT pcO_o,
	output wbT   wb_o
);

	dataT    pc;
	dataT    ifIdInstr;  // IF/ID
	idExT    idEx;
	idExT    idExNext;
	exMemT   exMem;
	exMemT   exMemNext;
	memWbT   memWb;
	ctrlT    ctrlId;
	dataT    rsVal;
	dataT    rtVal;
	dataT    immExt;
	dataT    memRData;
	dataT    wbData;
	logic    stall;
	fwdSelE  fwdA;
	fwdSelE  fwdB;

	////////////////////////////// Fetch
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			pc        <= '0;
			ifIdInstr <= '0;         // All-zero word decodes as no-op
		end else if (!stall) begin  // Load-use holds PC and IF/ID
			pc        <= pc + 32'd4;
			ifIdInstr <= instr_i;
		end
	end

	assign pcO_o = pc;

	////////////////////////////// Decode
	controlUnit uCtrl (
		.opcode_i(opcodeE'(ifIdInstr[31:26])),
		.funct_i (functE'(ifIdInstr[5:0])),
		.ctrl_o  (ctrlId)
	);

	registerFile uRegs (
		.clk_i   (clk_i),
		.rstN_i  (rstN_i),
		.we_i    (memWb.regWrite),
		.wAddr_i (memWb.dest),
		.wData_i (wbData),
		.rAddrA_i(ifIdInstr[25:21]),
		.rAddrB_i(ifIdInstr[20:16]),
		.rDataA_o(rsVal),
		.rDataB_o(rtVal)
	);

	hazardUnit uHazard (
		.ifIdRs_i(ifIdInstr[25:21]),
		.ifIdRt_i(ifIdInstr[20:16]),
		.idEx_i  (idEx),
		.exMem_i (exMem),
		.memWb_i (memWb),
		.stall_o (stall),
		.fwdA_o  (fwdA),
		.fwdB_o  (fwdB)
	);

	assign immExt = ctrlId.zeroExt ? {16'h0000, ifIdInstr[15:0]}   // andi, ori
	                               : {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

	always_comb begin
		idExNext.ctrl  = stall ? '0 : ctrlId;  // Bubble into EX
		idExNext.rsVal = rsVal;
		idExNext.rtVal = rtVal;
		idExNext.imm   = immExt;
		idExNext.rs    = ifIdInstr[25:21];
		idExNext.rt    = ifIdInstr[20:16];
		idExNext.rd    = ifIdInstr[15:11];
	end

	////////////////////////////// Execute and memory
	executeStage uExec (
		.idEx_i    (idEx),
		.fwdA_i    (fwdA),
		.fwdB_i    (fwdB),
		.exMemRes_i(exMem.aluRes),
		.memWbRes_i(wbData),
		.exMem_o   (exMemNext)
	);

	dataMemory uDMem (
		.clk_i  (clk_i),
		.rstN_i (rstN_i),
		.we_i   (exMem.memWrite),
		.addr_i (exMem.aluRes),
		.wData_i(exMem.storeData),
		.rData_o(memRData)
	);

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			idEx  <= '0;
			exMem <= '0;
			memWb <= '0;
		end else begin
			idEx           <= idExNext;
			exMem          <= exMemNext;
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.aluRes   <= exMem.aluRes;
			memWb.loadData <= exMem.memRead ? memRData : '0;  // Only loads sample memory
			memWb.dest     <= exMem.dest;
		end
	end

	////////////////////////////// Writeback
	assign wbData     = memWb.memToReg ? memWb.loadData : memWb.aluRes;
	assign wb_o.valid = memWb.regWrite && (memWb.dest != '0);  // $zero writes are dropped
	assign wb_o.idx   = memWb.dest;
	assign wb_o.data  = wbData;

endmodule

// ==== design/dataMemory.sv ====
/*
 * dataMemory
 * 64-word data RAM, word index from address bits 7:2 so higher
 * addresses wrap. Combinational read, clocked write
 */
`timescale 1ns/1ps

module dataMemory
	import mipsPkg::*;
(
	input  logic clk_i,
	input  logic rstN_i,
	input  logic we_i,
	input  dataT addr_i,   // Byte address
	input  dataT wData_i,
	output dataT rData_o
);

	localparam int idxWidth = $clog2(dMemDepth);

	dataT                mem [dMemDepth];
	logic [idxWidth-1:0] wordIdx;

	assign wordIdx = addr_i[idxWidth+1:2];  // Drop byte offset

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < dMemDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (we_i) begin
			mem[wordIdx] <= wData_i;
		end
	end

	assign rData_o = mem[wordIdx];

endmodule

// ==== design/executeStage.sv ====
/*
 * executeStage
 * Operand forwarding, ALU source select, the ALU itself and the
 * destination select. Builds the next EX/MEM contents
 */
`timescale 1ns/1ps

module executeStage
	import mipsPkg::*;
(
	input  idExT   idEx_i,
	input  fwdSelE fwdA_i,
	input  fwdSelE fwdB_i,
	input  dataT   exMemRes_i,  // ALU result in EX/MEM
	input  dataT   memWbRes_i,  // Writeback data in MEM/WB
	output exMemT  exMem_o
);

	dataT opA;
	dataT opB;
	dataT srcB;
	dataT aluRes;

	function automatic dataT fwdMux(input fwdSelE sel, input dataT regVal);
		unique case (sel)
			fwdExMem: return exMemRes_i;
			fwdMemWb: return memWbRes_i;
			default:  return regVal;
		endcase
	endfunction

	////////////////////////////// Operands
	assign opA  = fwdMux(fwdA_i, idEx_i.rsVal);
	assign opB  = fwdMux(fwdB_i, idEx_i.rtVal);
	assign srcB = idEx_i.ctrl.aluSrc ? idEx_i.imm : opB;

	////////////////////////////// ALU
	always_comb begin
		unique case (idEx_i.ctrl.aluOp)
			aluSub:  aluRes = opA - srcB;
			aluAnd:  aluRes = opA & srcB;
			aluOr:   aluRes = opA | srcB;
			aluNor:  aluRes = ~(opA | srcB);
			aluSlt:  aluRes = ($signed(opA) < $signed(srcB)) ? 32'd1 : 32'd0;  // Signed compare
			default: aluRes = opA + srcB;  // add, addi, address calc
		endcase
	end

	always_comb begin
		exMem_o.regWrite  = idEx_i.ctrl.regWrite;
		exMem_o.memToReg  = idEx_i.ctrl.memToReg;
		exMem_o.memWrite  = idEx_i.ctrl.memWrite;
		exMem_o.memRead   = idEx_i.ctrl.memRead;
		exMem_o.aluRes    = aluRes;
		exMem_o.storeData = opB;  // Forwarded rt for sw
		exMem_o.dest      = idEx_i.ctrl.regDst ? idEx_i.rd : idEx_i.rt;
	end

endmodule

// ==== design/hazardUnit.sv ====
/*
 * hazardUnit
 * Load-use stall detection for the instruction in decode and the
 * forwarding selects for the two operands in execute
 */
`timescale 1ns/1ps

module hazardUnit
	import mipsPkg::*;
(
	input  regAddrT ifIdRs_i,
	input  regAddrT ifIdRt_i,
	input  idExT    idEx_i,
	input  exMemT   exMem_i,
	input  memWbT   memWb_i,
	output logic    stall_o,
	output fwdSelE  fwdA_o,
	output fwdSelE  fwdB_o
);

	// EX/MEM wins over MEM/WB, the younger result
	function automatic fwdSelE fwdSel(input regAddrT src);
		if (exMem_i.regWrite && (exMem_i.dest != '0) && (exMem_i.dest == src))
			return fwdExMem;
		else if (memWb_i.regWrite && (memWb_i.dest != '0) && (memWb_i.dest == src))
			return fwdMemWb;
		else
			return fwdReg;
	endfunction

	// Load in EX, consumer in decode
	assign stall_o = idEx_i.ctrl.memRead &&
	                 ((idEx_i.rt == ifIdRs_i) || (idEx_i.rt == ifIdRt_i));

	assign fwdA_o = fwdSel(idEx_i.rs);
	assign fwdB_o = fwdSel(idEx_i.rt);

endmodule

// ==== design/registerFile.sv ====
/*
 * registerFile
 * 32 x 32 register file, two combinational read ports with
 * write-through, one clocked write port. $zero reads as zero
 */
`timescale 1ns/1ps

module registerFile
	import mipsPkg::*;
(
	input  logic    clk_i,
	input  logic    rstN_i,
	input  logic    we_i,
	input  regAddrT wAddr_i,
	input  dataT    wData_i,
	input  regAddrT rAddrA_i,
	input  regAddrT rAddrB_i,
	output dataT    rDataA_o,
	output dataT    rDataB_o
);

	dataT regs [2**regAddrWidth];

	// Read with bypass of the value written this cycle
	function automatic dataT readPort(input regAddrT addr);
		if (addr == '0)
			return '0;
		else if (we_i && (wAddr_i == addr))
			return wData_i;  // Write-through
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (wAddr_i != '0)) begin
			regs[wAddr_i] <= wData_i;
		end
	end

	assign rDataA_o = readPort(rAddrA_i);
	assign rDataB_o = readPort(rAddrB_i);

endmodule

// ==== design/controlUnit.sv ====
/*
 * controlUnit
 * Main decoder, maps opcode and funct to the control set and the
 * ALU operation. Unknown encodings give all-zero control
 */
`timescale 1ns/1ps

module controlUnit
	import mipsPkg::*;
(
	input  opcodeE opcode_i,
	input  functE  funct_i,
	output ctrlT   ctrl_o
);

	always_comb begin
		ctrl_o = '0;  // No-op unless decoded below
		unique case (opcode_i)
			opR: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.regDst   = 1'b1;  // Write rd
				unique case (funct_i)
					fnAdd:   ctrl_o.aluOp = aluAdd;
					fnSub:   ctrl_o.aluOp = aluSub;
					fnAnd:   ctrl_o.aluOp = aluAnd;
					fnOr:    ctrl_o.aluOp = aluOr;
					fnNor:   ctrl_o.aluOp = aluNor;
					fnSlt:   ctrl_o.aluOp = aluSlt;
					default: ctrl_o = '0;  // Unsupported funct, incl. sll $0
				endcase
			end
			opAddi: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.aluSrc   = 1'b1;
				ctrl_o.aluOp    = aluAdd;
			end
			opAndi, opOri: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.aluSrc   = 1'b1;
				ctrl_o.zeroExt  = 1'b1;
				ctrl_o.aluOp    = (opcode_i == opAndi) ? aluAnd : aluOr;
			end
			opLw: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.memToReg = 1'b1;
				ctrl_o.memRead  = 1'b1;
				ctrl_o.aluSrc   = 1'b1;  // Base plus offset
				ctrl_o.aluOp    = aluAdd;
			end
			opSw: begin
				ctrl_o.memWrite = 1'b1;
				ctrl_o.aluSrc   = 1'b1;
				ctrl_o.aluOp    = aluAdd;
			end
			default: ctrl_o = '0;
		endcase
	end

endmodule

// ==== design/mipsPkg.sv ====
/*
 * mipsPkg
 * Widths, instruction encodings and pipeline-register types
 * shared by every block of the five-stage MIPS core
 */
package mipsPkg;

	parameter int dataWidth    = 32;  // Data path width
	parameter int regAddrWidth = 5;   // Register index width
	parameter int dMemDepth    = 64;  // Data memory words, indexed by address bits 7:2

	typedef logic [dataWidth-1:0]    dataT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	typedef enum logic [5:0] {
		opR    = 6'h00,  // R-type, funct selects the ALU op
		opAddi = 6'h08,
		opAndi = 6'h0C,
		opOri  = 6'h0D,
		opLw   = 6'h23,
		opSw   = 6'h2B
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27,
		fnSlt = 6'h2A
	} functE;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluNor, aluSlt} aluOpE;

	// Operand source for the EX stage
	typedef enum logic [1:0] {fwdReg = 2'b00, fwdMemWb = 2'b01, fwdExMem = 2'b10} fwdSelE;

	typedef struct packed {
		logic  regWrite;
		logic  memToReg;  // Writeback takes load data
		logic  memWrite;
		logic  memRead;
		logic  regDst;    // Destination is rd
		logic  aluSrc;    // Second operand is the immediate
		logic  zeroExt;   // Immediate is zero extended
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		ctrlT    ctrl;
		dataT    rsVal;
		dataT    rtVal;
		dataT    imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memWrite;
		logic    memRead;
		dataT    aluRes;
		dataT    storeData;
		regAddrT dest;
	} exMemT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		dataT    aluRes;
		dataT    loadData;
		regAddrT dest;
	} memWbT;

	typedef struct packed {
		logic    valid;
		regAddrT idx;
		dataT    data;
	} wbT;

endpackage
